// File: src/ib_consts.svh
`ifndef IB_CONSTS_SVH
`define IB_CONSTS_SVH

// ------------------------------
// line bank geometry
// ------------------------------
`define IB_NUM_LINES   28 // line memories in the bank
`define IB_CELL_DEPTH  16 // cells per line
`define IB_ADDR_W      4
`define IB_LINE_IDX_W  5

// ------------------------------
// data layout
// ------------------------------
`define IB_ELEM_W      32
`define IB_ELEMS       4  // elements per line word
`define IB_WIN_LINES   4  // lines seen by the PE array at once
`define IB_WORD_W      (`IB_ELEMS * `IB_ELEM_W)
`define IB_WIN_W       (`IB_WIN_LINES * `IB_WORD_W)

// window index, wide enough for 13 overlapping windows of a 3x3 scan
`define IB_WIN_IDX_W   4

`endif

// File: src/ib_pkg.sv
`default_nettype none

`include "ib_consts.svh"

package ib_pkg;

	// one line word, stored raw and taken apart per element by the transpose
	typedef union packed {
		logic [`IB_WORD_W-1:0] raw;
		logic [`IB_ELEMS-1:0][`IB_ELEM_W-1:0] elem; // elem[0] in the low bits
	} line_word_u;

endpackage

`default_nettype wire

// File: src/ib_bank_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

interface ib_bank_if;
	import ib_pkg::*;

	// write side, from the fill counters
	logic [`IB_NUM_LINES-1:0] wr_en; // one-hot per line
	logic [`IB_ADDR_W-1:0] wr_addr;
	logic [`IB_WORD_W-1:0] wr_data;

	// read side, from the scan counters
	logic [`IB_ADDR_W-1:0] rd_addr;
	logic [`IB_WIN_IDX_W-1:0] win_idx;

	line_word_u win_lines [`IB_WIN_LINES]; // selected window, line 0 first

	modport fill (
		output wr_en,
		output wr_addr,
		output wr_data
	);

	modport scan (
		output rd_addr,
		output win_idx
	);

	modport bank (
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_addr,
		input  win_idx,
		output win_lines
	);

endinterface

`default_nettype wire

// File: src/ib_fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

module ib_fill_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic wr_strobe,
	input  logic [`IB_WORD_W-1:0] wr_word,
	input  logic [7:0] cell_num, // last cell index of a line
	input  logic [7:0] line_num, // last line index of the frame
	ib_bank_if.fill bus
);

	logic [7:0] cell_cnt;
	logic [7:0] line_cnt;
	logic line_last_cell;

	assign line_last_cell = (cell_cnt == cell_num);

	// ------------------------------
	// cell and line counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cell_cnt <= '0;
			line_cnt <= '0;
		end else if (wr_strobe) begin
			if (line_last_cell) begin
				cell_cnt <= '0;
				if (line_cnt == line_num)
					line_cnt <= '0; // frame complete
				else
					line_cnt <= line_cnt + 8'd1;
			end else begin
				cell_cnt <= cell_cnt + 8'd1;
			end
		end
	end

	// ------------------------------
	// write enable decode
	// ------------------------------
	always_comb begin
		for (int i = 0; i < `IB_NUM_LINES; i++) begin
			bus.wr_en[i] = wr_strobe && (line_cnt == 8'(i));
		end
	end

	assign bus.wr_addr = cell_cnt[`IB_ADDR_W-1:0]; // cell_num stays below the depth
	assign bus.wr_data = wr_word;

endmodule

`default_nettype wire

// File: src/ib_scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

module ib_scan_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic scan_en,
	input  logic [4:0] num_switch_h, // plain steps between two skips
	input  logic [8:0] num_slide_h,  // last read address of a sweep
	input  logic [4:0] num_slide_v,  // last window of the layer
	input  logic channel_done,
	output logic save_done,
	output logic layer_finish,
	ib_bank_if.scan bus
);

	logic [4:0] jump_cnt;
	logic [`IB_ADDR_W-1:0] rd_addr;
	logic [`IB_WIN_IDX_W-1:0] win_idx;
	logic jump_now;

	assign jump_now = (jump_cnt == num_switch_h);

	// sweep and layer flags, straight from the counters
	assign save_done = ({5'd0, rd_addr} == num_slide_h);
	assign layer_finish = ({1'b0, win_idx} == num_slide_v) && channel_done;

	// ------------------------------
	// horizontal address
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || save_done) begin
			jump_cnt <= '0;
			rd_addr <= '0;
		end else if (scan_en) begin
			if (jump_now) begin
				jump_cnt <= '0;
				rd_addr <= rd_addr + 4'd2; // skip one cell
			end else begin
				jump_cnt <= jump_cnt + 5'd1;
				rd_addr <= rd_addr + 4'd1;
			end
		end
	end

	// ------------------------------
	// vertical window index
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || layer_finish)
			win_idx <= '0;
		else if (save_done)
			win_idx <= win_idx + 4'd1; // next window once the sweep ends
	end

	assign bus.rd_addr = rd_addr;
	assign bus.win_idx = win_idx;

endmodule

`default_nettype wire

// File: src/ib_line_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

module ib_line_bank (
	input  logic clk,
	input  logic kernel_3x3, // 1: overlapping windows, 0: disjoint
	ib_bank_if.bank bus,
	output ib_pkg::line_word_u win_lines [`IB_WIN_LINES]
);

	logic [`IB_WORD_W-1:0] line_q [`IB_NUM_LINES]; // async read of every line
	logic [`IB_LINE_IDX_W:0] win_base;
	logic [`IB_LINE_IDX_W:0] sel_idx [`IB_WIN_LINES];

	// ------------------------------
	// line memories
	// ------------------------------
	for (genvar g = 0; g < `IB_NUM_LINES; g++) begin : g_line
		logic [`IB_WORD_W-1:0] mem [`IB_CELL_DEPTH];

		always_ff @(posedge clk) begin
			if (bus.wr_en[g])
				mem[bus.wr_addr] <= bus.wr_data;
		end

		assign line_q[g] = mem[bus.rd_addr];
	end

	// ------------------------------
	// window select
	// ------------------------------
	// 3x3 steps by two lines, 1x1 by four
	assign win_base = kernel_3x3 ? {1'b0, bus.win_idx, 1'b0} : {bus.win_idx, 2'b00};

	always_comb begin
		for (int k = 0; k < `IB_WIN_LINES; k++) begin
			sel_idx[k] = win_base + 6'(k);
			// windows past the last line read as zero
			if (sel_idx[k] < 6'(`IB_NUM_LINES))
				bus.win_lines[k].raw = line_q[sel_idx[k][`IB_LINE_IDX_W-1:0]];
			else
				bus.win_lines[k].raw = '0;
		end
	end

	assign win_lines = bus.win_lines;

endmodule

`default_nettype wire

// File: src/ib_window_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

module ib_window_pipe (
	input  logic clk,
	input  logic kernel_3x3,
	input  ib_pkg::line_word_u win_lines [`IB_WIN_LINES],
	output logic [`IB_WIN_W-1:0] window_out
);

	logic [`IB_WIN_W-1:0] trans;
	logic [`IB_WIN_W-1:0] stage_1; // 3x3 output
	logic [`IB_WIN_W-1:0] stage_2; // extra stage for 1x1

	// ------------------------------
	// transpose to element-major
	// ------------------------------
	// group j holds element j of lines 3..0, line 0 lowest
	for (genvar j = 0; j < `IB_ELEMS; j++) begin : g_elem
		for (genvar k = 0; k < `IB_WIN_LINES; k++) begin : g_line
			assign trans[(j*`IB_WIN_LINES + k)*`IB_ELEM_W +: `IB_ELEM_W] =
				win_lines[k].elem[j];
		end
	end

	// ------------------------------
	// output registers
	// ------------------------------
	always_ff @(posedge clk) begin
		stage_1 <= trans;
		stage_2 <= stage_1;
	end

	assign window_out = kernel_3x3 ? stage_1 : stage_2;

endmodule

`default_nettype wire

// File: src/input_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

module input_buffer (
	input  logic clk,
	input  logic reset,

	// feature stream in
	input  logic wr_strobe,
	input  logic [`IB_WORD_W-1:0] wr_word,
	input  logic [7:0] cell_num,
	input  logic [7:0] line_num,

	// scan control
	input  logic scan_en,
	input  logic kernel_3x3, // 1: 3x3 kernel, 0: 1x1
	input  logic [4:0] num_switch_h,
	input  logic [8:0] num_slide_h,
	input  logic [4:0] num_slide_v,
	input  logic channel_done,

	// window out to the PE array
	output logic [`IB_WIN_W-1:0] window_out,
	output logic save_done,
	output logic layer_finish
);
	import ib_pkg::*;

	line_word_u win_lines [`IB_WIN_LINES];

	ib_bank_if bus ();

	// ------------------------------
	// controllers
	// ------------------------------
	ib_fill_ctrl u_fill_ctrl (
		.clk       (clk),
		.reset     (reset),
		.wr_strobe (wr_strobe),
		.wr_word   (wr_word),
		.cell_num  (cell_num),
		.line_num  (line_num),
		.bus       (bus.fill)
	);

	ib_scan_ctrl u_scan_ctrl (
		.clk          (clk),
		.reset        (reset),
		.scan_en      (scan_en),
		.num_switch_h (num_switch_h),
		.num_slide_h  (num_slide_h),
		.num_slide_v  (num_slide_v),
		.channel_done (channel_done),
		.save_done    (save_done),
		.layer_finish (layer_finish),
		.bus          (bus.scan)
	);

	// ------------------------------
	// storage and output path
	// ------------------------------
	ib_line_bank u_line_bank (
		.clk        (clk),
		.kernel_3x3 (kernel_3x3),
		.bus        (bus.bank),
		.win_lines  (win_lines)
	);

	ib_window_pipe u_window_pipe (
		.clk        (clk),
		.kernel_3x3 (kernel_3x3),
		.win_lines  (win_lines),
		.window_out (window_out)
	);

endmodule

`default_nettype wire

// File: sim/tb_input_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ib_consts.svh"

module tb_input_buffer;

	localparam logic [31:0] LFSR_SEED = 32'h9e5f_e0b7;
	localparam int NUM_PHASES = 4; // 3x3 and 1x1 in turn
	localparam int FILL_CYCLES = 16 + `IB_NUM_LINES * `IB_CELL_DEPTH + 2;
	// two layers of up to 13 windows, 16 cells each, doubled for the stalls
	localparam int SCAN_CYCLES = 2 * 13 * `IB_CELL_DEPTH * 2 + 2;
	localparam int CYCLE_LIMIT = NUM_PHASES * (FILL_CYCLES + SCAN_CYCLES) * 2 + 200;

	logic clk;
	logic reset;
	logic wr_strobe;
	logic [`IB_WORD_W-1:0] wr_word;
	logic [7:0] cell_num;
	logic [7:0] line_num;
	logic scan_en;
	logic kernel_3x3;
	logic [4:0] num_switch_h;
	logic [8:0] num_slide_h;
	logic [4:0] num_slide_v;
	logic channel_done;
	logic [`IB_WIN_W-1:0] window_out;
	logic save_done;
	logic layer_finish;

	// reference model state
	logic [`IB_WORD_W-1:0] shadow [`IB_NUM_LINES][`IB_CELL_DEPTH];
	logic [3:0] m_rd;
	logic [4:0] m_jump;
	logic [3:0] m_win;
	logic [`IB_WIN_W-1:0] hist [2]; // hist[0] newest
	int hist_cnt;
	bit scan_active;
	int finishes;
	int cycle_cnt;
	logic [31:0] lfsr;

	// per-phase settings
	logic cfg_kernel;
	logic [4:0] cfg_switch;
	logic [8:0] cfg_slide_h;
	logic [4:0] cfg_slide_v;

	input_buffer dut0 (
		.clk          (clk),
		.reset        (reset),
		.wr_strobe    (wr_strobe),
		.wr_word      (wr_word),
		.cell_num     (cell_num),
		.line_num     (line_num),
		.scan_en      (scan_en),
		.kernel_3x3   (kernel_3x3),
		.num_switch_h (num_switch_h),
		.num_slide_h  (num_slide_h),
		.num_slide_v  (num_slide_v),
		.channel_done (channel_done),
		.window_out   (window_out),
		.save_done    (save_done),
		.layer_finish (layer_finish)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ------------------------------
	// random source
	// ------------------------------
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [`IB_WORD_W-1:0] random_word();
		logic [`IB_WORD_W-1:0] w;
		w = '0;
		for (int i = 0; i < `IB_ELEMS; i++)
			w = {w[`IB_WORD_W-`IB_ELEM_W-1:0], rand_bits(32)};
		return w;
	endfunction

	// an end address that the skip pattern really hits, starting from cell 0
	function automatic logic [8:0] reachable_addr(logic [4:0] sw);
		int addrs[$];
		int a;
		int j;
		a = 0;
		j = 0;
		while (1) begin
			if (j == sw) begin
				a += 2;
				j = 0;
			end else begin
				a += 1;
				j++;
			end
			if (a > `IB_CELL_DEPTH - 1)
				break;
			addrs.push_back(a);
		end
		return 9'(addrs[rand_bits(4) % addrs.size()]);
	endfunction

	// group j = element j of lines 3..0, line 0 in the low bits
	function automatic logic [`IB_WIN_W-1:0] expected_window(logic k3, logic [3:0] win,
			logic [3:0] addr);
		int base;
		logic [`IB_WORD_W-1:0] l0;
		logic [`IB_WORD_W-1:0] l1;
		logic [`IB_WORD_W-1:0] l2;
		logic [`IB_WORD_W-1:0] l3;
		logic [`IB_WIN_W-1:0] w;
		base = k3 ? 2 * win : 4 * win;
		l0 = shadow[base][addr];
		l1 = shadow[base + 1][addr];
		l2 = shadow[base + 2][addr];
		l3 = shadow[base + 3][addr];
		for (int j = 0; j < `IB_ELEMS; j++)
			w[j*`IB_WORD_W +: `IB_WORD_W] = {l3[j*32 +: 32], l2[j*32 +: 32],
				l1[j*32 +: 32], l0[j*32 +: 32]};
		return w;
	endfunction

	task automatic stop_on_error();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// ------------------------------
	// checks and model step
	// ------------------------------
	// runs at the falling edge, then steps the model as the DUT steps at the next rise
	task automatic check_and_step();
		logic exp_sd;
		logic exp_lf;
		int lat;
		exp_sd = (9'(m_rd) == num_slide_h);
		exp_lf = (5'(m_win) == num_slide_v) && channel_done;
		assert (save_done === exp_sd) else begin
			$display("Mismatch save_done: got %h, expected %h", save_done, exp_sd);
			stop_on_error();
		end
		assert (layer_finish === exp_lf) else begin
			$display("Mismatch layer_finish: got %h, expected %h", layer_finish, exp_lf);
			stop_on_error();
		end
		if (scan_active) begin
			lat = kernel_3x3 ? 1 : 2;
			if (hist_cnt >= lat) begin
				assert (window_out === hist[lat-1]) else begin
					$display("Mismatch window_out: got %h, expected %h",
						window_out, hist[lat-1]);
					stop_on_error();
				end
			end
			hist[1] = hist[0];
			hist[0] = expected_window(kernel_3x3, m_win, m_rd);
			if (hist_cnt < 2)
				hist_cnt++;
			if (exp_lf)
				finishes++;
		end
		if (exp_sd) begin
			m_rd = '0; // sweep done, back to cell 0
			m_jump = '0;
		end else if (scan_en) begin
			if (m_jump == num_switch_h) begin
				m_rd = m_rd + 4'd2;
				m_jump = '0;
			end else begin
				m_rd = m_rd + 4'd1;
				m_jump = m_jump + 5'd1;
			end
		end
		if (exp_lf)
			m_win = '0;
		else if (exp_sd)
			m_win = m_win + 4'd1;
	endtask

	// ------------------------------
	// phase tasks
	// ------------------------------
	task automatic choose_config(input logic k3);
		cfg_kernel = k3;
		cfg_switch = 5'(rand_bits(2));
		cfg_slide_h = reachable_addr(cfg_switch);
		// last window must stay inside the 28 lines
		cfg_slide_v = k3 ? 5'(rand_bits(4) % 13) : 5'(rand_bits(3) % 7);
	endtask

	task automatic reset_dut();
		@(posedge clk);
		reset <= 1'b1;
		wr_strobe <= 1'b0;
		scan_en <= 1'b0;
		channel_done <= 1'b0;
		kernel_3x3 <= cfg_kernel;
		num_switch_h <= cfg_switch;
		num_slide_h <= cfg_slide_h;
		num_slide_v <= cfg_slide_v;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		m_rd = '0;
		m_jump = '0;
		m_win = '0;
		hist_cnt = 0;
		scan_active = 0;
		@(negedge clk);
		assert (!save_done && !layer_finish) else begin
			$display("save_done or layer_finish is high right after reset");
			stop_on_error();
		end
		check_and_step();
	endtask

	task automatic fill_lines();
		logic [`IB_WORD_W-1:0] word;
		for (int l = 0; l < `IB_NUM_LINES; l++) begin
			for (int c = 0; c < `IB_CELL_DEPTH; c++) begin
				word = random_word();
				@(posedge clk);
				wr_strobe <= 1'b1;
				wr_word <= word;
				shadow[l][c] = word;
				@(negedge clk);
				check_and_step();
			end
		end
		@(posedge clk);
		wr_strobe <= 1'b0;
		@(negedge clk);
		check_and_step();
	endtask

	task automatic scan_layers();
		logic en;
		logic ch;
		scan_active = 1;
		hist_cnt = 0;
		finishes = 0;
		while (finishes < 2) begin
			en = (rand_bits(2) != 0); // about one stall in four
			ch = lfsr_bit();
			// in the last window the channel completes only as its sweep ends
			if (5'(m_win) == cfg_slide_v)
				ch = (9'(m_rd) == cfg_slide_h);
			@(posedge clk);
			scan_en <= en;
			channel_done <= ch;
			@(negedge clk);
			check_and_step();
		end
		repeat (2) begin
			@(posedge clk);
			scan_en <= 1'b0;
			channel_done <= 1'b1;
			@(negedge clk);
			check_and_step();
		end
		scan_active = 0;
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	initial cycle_cnt = 0;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			stop_on_error();
		end
	end

	initial begin
		lfsr = LFSR_SEED;
		reset = 1'b1;
		wr_strobe = 1'b0;
		wr_word = '0;
		cell_num = 8'(`IB_CELL_DEPTH - 1);
		line_num = 8'(`IB_NUM_LINES - 1);
		scan_en = 1'b0;
		kernel_3x3 = 1'b1;
		num_switch_h = '0;
		num_slide_h = 9'd1;
		num_slide_v = '0;
		channel_done = 1'b0;
		for (int p = 0; p < NUM_PHASES; p++) begin
			choose_config(p % 2 == 0);
			reset_dut();
			fill_lines();
			scan_layers();
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/ib_pkg.sv
src/ib_bank_if.sv
src/ib_fill_ctrl.sv
src/ib_scan_ctrl.sv
src/ib_line_bank.sv
src/ib_window_pipe.sv
src/input_buffer.sv
sim/tb_input_buffer.sv
